//--- src/cu_cache_pkg.sv
/* Shared widths, depths and latencies of the compute-unit front end
   Command codes and the request, descriptor and response payload structs */

package cu_cache_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  // 1024-word store
  localparam int ADDR_W = 10;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int TAG_W  = 8;

  // ------------------------------
  // FIFO sizing and store timing
  // ------------------------------
  localparam int FIFO_DEPTH   = 16;
  // Response fill level that stops issue
  localparam int PROG_THRESH  = 12;
  // Cycles from read accept to rvalid
  localparam int READ_LATENCY = 2;

  // ------------------------------
  // Payload types
  // ------------------------------
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_e;

  // Kernel descriptor, only the base word address is used
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
  } descriptor_t;

  // Request as seen at the top-level ports
  typedef struct packed {
    cmd_e              cmd;
    logic [ADDR_W-1:0] offset;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [TAG_W-1:0]  tag;
  } mem_request_t;

  // Request after base mapping, addr is absolute
  // Strobes are zero for reads
  typedef struct packed {
    cmd_e              cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [TAG_W-1:0]  tag;
  } cache_request_t;

  typedef struct packed {
    cmd_e              cmd;
    logic [TAG_W-1:0]  tag;
    logic [DATA_W-1:0] rdata;
  } mem_response_t;

endpackage : cu_cache_pkg

//--- src/cu_store_if.sv
/* Command and data bus between the sequencer and the word store */

interface cu_store_if;
  import cu_cache_pkg::*;

  // Command side, accepted on valid and ready
  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  // All-zero strobes select a read
  logic [STRB_W-1:0] wstrb;

  // Return side
  logic [DATA_W-1:0] rdata;
  logic              rvalid;
  logic              ready;

  modport sequencer (
    output valid, addr, wdata, wstrb,
    input  rdata, rvalid, ready
  );

  modport store (
    input  valid, addr, wdata, wstrb,
    output rdata, rvalid, ready
  );

endinterface : cu_store_if

//--- src/cu_sync_fifo.sv
/* Synchronous first-word-fall-through FIFO for any payload type
   Count-based empty, almost-full and programmable-full flags */

module cu_sync_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16,
  parameter int  THRESH    = 12
) (
  input  logic     ap_clk,
  input  logic     areset_control,
  input  logic     push_i,
  input  payload_t din_i,
  input  logic     pop_i,
  output payload_t dout_o,
  output logic     empty_o,
  output logic     almost_full_o,
  output logic     prog_full_o
);

  // DEPTH is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Guard the storage against misuse from outside
  assign do_push = push_i & (count_q != CNT_W'(DEPTH));
  assign do_pop  = pop_i & (count_q != '0);

  // ------------------------------
  // Pointers and fill count
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  // Head is always on the output
  assign dout_o        = mem[rd_ptr_q];
  assign empty_o       = (count_q == '0);
  // Three spare slots absorb the writer's pipeline after the flag
  assign almost_full_o = (count_q >= CNT_W'(DEPTH - 3));
  assign prog_full_o   = (count_q >= CNT_W'(THRESH));

  a_no_push_full : assert property (@(posedge ap_clk) disable iff (areset_control)
    push_i |-> (count_q != CNT_W'(DEPTH)))
    else $error("FIFO push while full");

  a_no_pop_empty : assert property (@(posedge ap_clk) disable iff (areset_control)
    pop_i |-> (count_q != '0))
    else $error("FIFO pop while empty");

endmodule : cu_sync_fifo

//--- src/cu_request_mapper.sv
/* Descriptor capture and two-stage request input pipeline
   Second stage turns the offset into an absolute word address */

module cu_request_mapper (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  logic                           descriptor_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0] descriptor_base_i,
  input  logic                           request_valid_i,
  input  cu_cache_pkg::mem_request_t     request_i,
  output logic                           push_o,
  output cu_cache_pkg::cache_request_t   cache_request_o,
  output logic                           descriptor_seen_o
);
  import cu_cache_pkg::*;

  descriptor_t  descriptor_q;
  logic         stage1_valid_q;
  mem_request_t stage1_req_q;

  // ------------------------------
  // Descriptor
  // ------------------------------
  // Base clears to zero so early requests map to a known address
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      descriptor_seen_o      <= 1'b0;
      descriptor_q.base_addr <= '0;
    end else if (descriptor_valid_i) begin
      descriptor_seen_o      <= 1'b1;
      descriptor_q.base_addr <= descriptor_base_i;
    end
  end

  // ------------------------------
  // Input pipeline
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stage1_valid_q <= 1'b0;
      push_o         <= 1'b0;
    end else begin
      stage1_valid_q <= request_valid_i;
      push_o         <= stage1_valid_q;
    end
  end

  // Payload stages, qualified by the valid bits above
  always_ff @(posedge ap_clk) begin
    stage1_req_q          <= request_i;
    cache_request_o.cmd   <= stage1_req_q.cmd;
    // Address wraps inside the store
    cache_request_o.addr  <= descriptor_q.base_addr + stage1_req_q.offset;
    cache_request_o.wdata <= stage1_req_q.wdata;
    cache_request_o.wstrb <= (stage1_req_q.cmd == CMD_WRITE) ? stage1_req_q.wstrb : '0;
    cache_request_o.tag   <= stage1_req_q.tag;
  end

endmodule : cu_request_mapper

//--- src/cu_command_sequencer.sv
/* In-order issue of mapped requests to the word store
   Builds one response per completed command */

module cu_command_sequencer (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  cu_cache_pkg::cache_request_t head_i,
  input  logic                         head_empty_i,
  input  logic                         descriptor_seen_i,
  input  logic                         resp_prog_full_i,
  output logic                         pop_o,
  output logic                         resp_push_o,
  output cu_cache_pkg::mem_response_t  resp_o,
  cu_store_if.sequencer                store
);
  import cu_cache_pkg::*;

  logic read_pending_q;
  logic can_issue;
  logic head_is_read;
  logic issue_read;
  logic issue_write;

  assign head_is_read = (head_i.cmd == CMD_READ);

  // ------------------------------
  // Issue rule
  // ------------------------------
  // Only one read in flight, head stays put until its data returns
  assign can_issue = ~head_empty_i & ~resp_prog_full_i & descriptor_seen_i
                   & store.ready & ~read_pending_q;

  assign issue_read  = can_issue & head_is_read;
  assign issue_write = can_issue & ~head_is_read;

  // Store command straight from the FIFO head
  // A write with no strobes still completes but skips the store
  assign store.valid = issue_read | (issue_write & (head_i.wstrb != '0));
  assign store.addr  = head_i.addr;
  assign store.wdata = head_i.wdata;
  assign store.wstrb = head_i.wstrb;

  // Read accepted, wait for rvalid
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      read_pending_q <= 1'b0;
    end else if (issue_read) begin
      read_pending_q <= 1'b1;
    end else if (store.rvalid) begin
      read_pending_q <= 1'b0;
    end
  end

  // ------------------------------
  // Completion
  // ------------------------------
  // Writes retire on issue, reads on returned data
  assign pop_o       = issue_write | (read_pending_q & store.rvalid);
  assign resp_push_o = pop_o;

  assign resp_o.cmd   = head_i.cmd;
  assign resp_o.tag   = head_i.tag;
  // No data on write responses
  assign resp_o.rdata = head_is_read ? store.rdata : '0;

  // Store must only answer reads this side has issued
  a_rvalid_pending : assert property (@(posedge ap_clk) disable iff (areset_control)
    store.rvalid |-> read_pending_q)
    else $error("Store rvalid without a pending read");

endmodule : cu_command_sequencer

//--- src/cu_word_store.sv
/* Byte-strobed on-chip word memory
   Reads return after READ_LATENCY cycles, writes finish on accept */

module cu_word_store (
  input logic       ap_clk,
  input logic       areset_control,
  cu_store_if.store bus
);
  import cu_cache_pkg::*;

  localparam int WORDS = 2 ** ADDR_W;
  localparam int CNT_W = $clog2(READ_LATENCY + 1);

  logic [DATA_W-1:0] mem [WORDS];
  logic [DATA_W-1:0] rdata_q;
  logic [CNT_W-1:0]  countdown_q;
  logic              accept;
  logic              is_read;

  assign accept  = bus.valid & bus.ready;
  assign is_read = (bus.wstrb == '0);

  // ------------------------------
  // Read countdown
  // ------------------------------
  // Non-zero count means a read is in progress
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      countdown_q <= '0;
    end else if (accept & is_read) begin
      countdown_q <= CNT_W'(READ_LATENCY);
    end else if (countdown_q != '0) begin
      countdown_q <= countdown_q - 1'b1;
    end
  end

  assign bus.ready  = (countdown_q == '0);
  assign bus.rvalid = (countdown_q == CNT_W'(1));
  assign bus.rdata  = rdata_q;

  // ------------------------------
  // Memory array
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (accept & ~is_read) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.wstrb[b]) begin
          mem[bus.addr][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read word held until rvalid
  always_ff @(posedge ap_clk) begin
    if (accept & is_read) begin
      rdata_q <= mem[bus.addr];
    end
  end

endmodule : cu_word_store

//--- src/cu_cache_top.sv
/* Compute-unit memory front end top level
   Request and response FIFOs, sequencer, word store and output registers */

module cu_cache_top (
  input  logic                            ap_clk,
  input  logic                            areset_control,
  input  logic                            descriptor_valid_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0] descriptor_base_i,
  input  logic                            request_valid_i,
  input  logic                            request_cmd_i,
  input  logic [cu_cache_pkg::ADDR_W-1:0] request_offset_i,
  input  logic [cu_cache_pkg::DATA_W-1:0] request_wdata_i,
  input  logic [cu_cache_pkg::STRB_W-1:0] request_wstrb_i,
  input  logic [cu_cache_pkg::TAG_W-1:0]  request_tag_i,
  output logic                            response_valid_o,
  output logic                            response_cmd_o,
  output logic [cu_cache_pkg::TAG_W-1:0]  response_tag_o,
  output logic [cu_cache_pkg::DATA_W-1:0] response_rdata_o,
  input  logic                            response_ready_i,
  output logic                            request_full_o,
  output logic                            done_o
);
  import cu_cache_pkg::*;

  mem_request_t   request;
  logic           map_push;
  cache_request_t map_request;
  logic           descriptor_seen;
  cache_request_t req_head;
  logic           req_empty;
  logic           req_pop;
  logic           resp_push;
  mem_response_t  resp_din;
  mem_response_t  resp_head;
  logic           resp_empty;
  logic           resp_prog_full;
  logic           resp_pop;
  logic           idle_q;

  cu_store_if store_bus ();

  // Port bundle into a request struct
  assign request.cmd    = cmd_e'(request_cmd_i);
  assign request.offset = request_offset_i;
  assign request.wdata  = request_wdata_i;
  assign request.wstrb  = request_wstrb_i;
  assign request.tag    = request_tag_i;

  cu_request_mapper u_mapper (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .descriptor_valid_i (descriptor_valid_i),
    .descriptor_base_i  (descriptor_base_i),
    .request_valid_i    (request_valid_i),
    .request_i          (request),
    .push_o             (map_push),
    .cache_request_o    (map_request),
    .descriptor_seen_o  (descriptor_seen)
  );

  // Request queue, almost-full goes out as the full flag
  cu_sync_fifo #(
    .payload_t (cache_request_t),
    .DEPTH     (FIFO_DEPTH),
    .THRESH    (PROG_THRESH)
  ) u_req_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push_i         (map_push),
    .din_i          (map_request),
    .pop_i          (req_pop),
    .dout_o         (req_head),
    .empty_o        (req_empty),
    .almost_full_o  (request_full_o),
    .prog_full_o    ()
  );

  cu_command_sequencer u_sequencer (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .head_i            (req_head),
    .head_empty_i      (req_empty),
    .descriptor_seen_i (descriptor_seen),
    .resp_prog_full_i  (resp_prog_full),
    .pop_o             (req_pop),
    .resp_push_o       (resp_push),
    .resp_o            (resp_din),
    .store             (store_bus.sequencer)
  );

  cu_word_store u_store (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .bus            (store_bus.store)
  );

  // Response queue, prog_full throttles the sequencer
  cu_sync_fifo #(
    .payload_t (mem_response_t),
    .DEPTH     (FIFO_DEPTH),
    .THRESH    (PROG_THRESH)
  ) u_resp_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .push_i         (resp_push),
    .din_i          (resp_din),
    .pop_i          (resp_pop),
    .dout_o         (resp_head),
    .empty_o        (resp_empty),
    .almost_full_o  (),
    .prog_full_o    (resp_prog_full)
  );

  // ------------------------------
  // Outputs
  // ------------------------------
  // Drain one response per cycle while ready is held
  assign resp_pop = response_ready_i & ~resp_empty;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_valid_o <= 1'b0;
      idle_q           <= 1'b0;
      done_o           <= 1'b0;
    end else begin
      response_valid_o <= resp_pop;
      // Two register stages on the idle condition
      idle_q           <= req_empty & resp_empty & store_bus.ready;
      done_o           <= idle_q;
    end
  end

  // Payload follows the pop
  always_ff @(posedge ap_clk) begin
    if (resp_pop) begin
      response_cmd_o   <= resp_head.cmd;
      response_tag_o   <= resp_head.tag;
      response_rdata_o <= resp_head.rdata;
    end
  end

endmodule : cu_cache_top

//--- testbench/tb_cu_cache_top.sv
/* Directed testbench for the compute-unit memory front end
   Reference word model, response collector and one task per test */

module tb_cu_cache_top;
  import cu_cache_pkg::*;

  localparam logic [31:0] TB_SEED    = 32'h29d2_502a;
  localparam int          TB_TIMEOUT = 2000;
  localparam int          NUM_BURST  = 8;

  logic              ap_clk;
  logic              areset_control;
  logic              descriptor_valid_i;
  logic [ADDR_W-1:0] descriptor_base_i;
  logic              request_valid_i;
  logic              request_cmd_i;
  logic [ADDR_W-1:0] request_offset_i;
  logic [DATA_W-1:0] request_wdata_i;
  logic [STRB_W-1:0] request_wstrb_i;
  logic [TAG_W-1:0]  request_tag_i;
  logic              response_valid_o;
  logic              response_cmd_o;
  logic [TAG_W-1:0]  response_tag_o;
  logic [DATA_W-1:0] response_rdata_o;
  logic              response_ready_i;
  logic              request_full_o;
  logic              done_o;

  // Reference store by absolute word address
  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  logic [ADDR_W-1:0] cur_base;
  logic [TAG_W-1:0]  next_tag;
  mem_response_t     exp_q [$];
  mem_response_t     got_q [$];
  int                errors;
  int                tests;

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  cu_cache_top dut0 (
    .ap_clk             (ap_clk),
    .areset_control     (areset_control),
    .descriptor_valid_i (descriptor_valid_i),
    .descriptor_base_i  (descriptor_base_i),
    .request_valid_i    (request_valid_i),
    .request_cmd_i      (request_cmd_i),
    .request_offset_i   (request_offset_i),
    .request_wdata_i    (request_wdata_i),
    .request_wstrb_i    (request_wstrb_i),
    .request_tag_i      (request_tag_i),
    .response_valid_o   (response_valid_o),
    .response_cmd_o     (response_cmd_o),
    .response_tag_o     (response_tag_o),
    .response_rdata_o   (response_rdata_o),
    .response_ready_i   (response_ready_i),
    .request_full_o     (request_full_o),
    .done_o             (done_o)
  );

  // Registered outputs, sampled before the edge updates them
  always @(posedge ap_clk) begin
    if (!areset_control && response_valid_o === 1'b1) begin
      got_q.push_back({response_cmd_o, response_tag_o, response_rdata_o});
    end
  end

  // ------------------------------
  // Model and drivers
  // ------------------------------
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  // Called at a falling edge, returns one falling edge later
  task automatic send_request(input cmd_e cmd, input logic [ADDR_W-1:0] offset,
                              input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb);
    logic [ADDR_W-1:0] addr;
    addr = cur_base + offset;
    if (cmd == CMD_WRITE) begin
      ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, wstrb);
      exp_q.push_back({CMD_WRITE, next_tag, {DATA_W{1'b0}}});
    end else begin
      exp_q.push_back({CMD_READ, next_tag, ref_mem[addr]});
    end
    request_valid_i  = 1'b1;
    request_cmd_i    = cmd;
    request_offset_i = offset;
    request_wdata_i  = wdata;
    // Read strobes left random, the mapper clears them
    request_wstrb_i  = wstrb;
    request_tag_i    = next_tag;
    next_tag         = next_tag + 1'b1;
    @(negedge ap_clk);
    request_valid_i = 1'b0;
  endtask

  task automatic send_descriptor(input logic [ADDR_W-1:0] base);
    descriptor_valid_i = 1'b1;
    descriptor_base_i  = base;
    cur_base           = base;
    @(negedge ap_clk);
    descriptor_valid_i = 1'b0;
  endtask

  // Wait for every expected response, then compare in order
  task automatic check_responses(input string name);
    int            cycles;
    mem_response_t exp_r;
    mem_response_t got_r;
    cycles = 0;
    while (got_q.size() < exp_q.size() && cycles < TB_TIMEOUT) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (got_q.size() < exp_q.size()) begin
      $display("%s: timed out with %0d of %0d responses received", name, got_q.size(),
               exp_q.size());
      errors++;
    end
    while (exp_q.size() > 0 && got_q.size() > 0) begin
      exp_r = exp_q.pop_front();
      got_r = got_q.pop_front();
      if (got_r.cmd !== exp_r.cmd || got_r.tag !== exp_r.tag) begin
        $display("[FAIL] %0t %s: expected cmd %0d tag %h, got cmd %0d tag %h", $time, name,
                 exp_r.cmd, exp_r.tag, got_r.cmd, got_r.tag);
        errors++;
      end else if (exp_r.cmd == CMD_READ && got_r.rdata !== exp_r.rdata) begin
        $display("[FAIL] %0t %s: tag %h read %h, expected %h", $time, name, got_r.tag,
                 got_r.rdata, exp_r.rdata);
        errors++;
      end
    end
    if (got_q.size() != 0) begin
      $display("%s: %0d responses arrived that were never requested", name, got_q.size());
      errors++;
    end
    exp_q.delete();
    got_q.delete();
  endtask

  task automatic wait_done(input string name);
    int cycles;
    cycles = 0;
    while (done_o !== 1'b1 && cycles < TB_TIMEOUT) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (done_o !== 1'b1) begin
      $display("%s: done_o did not rise within %0d cycles", name, TB_TIMEOUT);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic test_reset();
    int start;
    start = errors;
    if (response_valid_o !== 1'b0 || request_full_o !== 1'b0) begin
      $display("[FAIL] %0t reset: response_valid_o or request_full_o high", $time);
      errors++;
    end
    wait_done("reset");
    // Maps with base zero, held in the queue until a descriptor arrives
    send_request(CMD_WRITE, 10'h005, 32'hcafe_0005, 4'hf);
    repeat (30) @(negedge ap_clk);
    if (got_q.size() != 0) begin
      $display("[FAIL] %0t reset: response before any descriptor", $time);
      errors++;
    end
    send_descriptor(10'h100);
    check_responses("reset");
    report_test("reset", start);
  endtask

  task automatic test_write_read();
    int                start;
    logic [ADDR_W-1:0] offs [NUM_BURST];
    start = errors;
    for (int i = 0; i < NUM_BURST; i++) begin
      offs[i] = ADDR_W'($urandom);
      send_request(CMD_WRITE, offs[i], $urandom, 4'hf);
    end
    for (int i = 0; i < NUM_BURST; i++) begin
      send_request(CMD_READ, offs[i], $urandom, STRB_W'($urandom));
    end
    check_responses("write_read");
    report_test("write_read", start);
  endtask

  task automatic test_partial();
    int                start;
    logic [ADDR_W-1:0] off;
    start = errors;
    for (int i = 0; i < NUM_BURST; i++) begin
      off = ADDR_W'($urandom);
      // Full word first so every byte is known
      send_request(CMD_WRITE, off, $urandom, 4'hf);
      send_request(CMD_WRITE, off, $urandom, STRB_W'($urandom));
      send_request(CMD_WRITE, off, $urandom, STRB_W'($urandom));
      send_request(CMD_READ, off, $urandom, 4'h0);
    end
    check_responses("partial");
    report_test("partial", start);
  endtask

  task automatic test_base();
    int start;
    start = errors;
    for (int i = 0; i < NUM_BURST; i++) begin
      send_request(CMD_WRITE, ADDR_W'(i), $urandom, 4'hf);
    end
    check_responses("base");
    // 0x3f8 + 0x108 wraps onto 0x100, the words just written
    send_descriptor(10'h3f8);
    for (int i = 0; i < NUM_BURST; i++) begin
      send_request(CMD_READ, 10'h108 + ADDR_W'(i), $urandom, 4'h0);
    end
    check_responses("base");
    report_test("base", start);
  endtask

  task automatic test_backpressure();
    int                start;
    int                count;
    logic [ADDR_W-1:0] off;
    start = errors;
    count = 0;
    response_ready_i = 1'b0;
    while (request_full_o !== 1'b1 && count < 64) begin
      off = 10'h040 + ADDR_W'(count / 2);
      if (count % 2 == 0) begin
        send_request(CMD_WRITE, off, $urandom, 4'hf);
      end else begin
        send_request(CMD_READ, off, $urandom, 4'h0);
      end
      count++;
    end
    if (request_full_o !== 1'b1) begin
      $display("backpressure: request_full_o never rose after %0d requests", count);
      errors++;
    end
    if (got_q.size() != 0) begin
      $display("[FAIL] %0t backpressure: response while ready was low", $time);
      errors++;
    end
    response_ready_i = 1'b1;
    check_responses("backpressure");
    report_test("backpressure", start);
  endtask

  task automatic test_done_drain();
    int start;
    start = errors;
    wait_done("done_drain");
    if (response_valid_o !== 1'b0) begin
      $display("[FAIL] %0t done_drain: response_valid_o high when idle", $time);
      errors++;
    end
    report_test("done_drain", start);
  endtask

  initial begin
    void'($urandom(TB_SEED));
    areset_control     = 1'b1;
    descriptor_valid_i = 1'b0;
    descriptor_base_i  = '0;
    request_valid_i    = 1'b0;
    request_cmd_i      = 1'b0;
    request_offset_i   = '0;
    request_wdata_i    = '0;
    request_wstrb_i    = '0;
    request_tag_i      = '0;
    response_ready_i   = 1'b1;
    cur_base           = '0;
    next_tag           = '0;
    errors             = 0;
    tests              = 0;
    repeat (16) @(negedge ap_clk);
    areset_control = 1'b0;
    test_reset();
    test_write_read();
    test_partial();
    test_base();
    test_backpressure();
    test_done_drain();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tb_cu_cache_top

//--- sim.f
src/cu_cache_pkg.sv
src/cu_store_if.sv
src/cu_sync_fifo.sv
src/cu_request_mapper.sv
src/cu_command_sequencer.sv
src/cu_word_store.sv
src/cu_cache_top.sv
testbench/tb_cu_cache_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cu_cache_top
RTL_TOP   ?= cu_cache_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
